/* source/rv_isa_pkg.sv */
package rv_isa_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;
    localparam int REG_AW   = $clog2(NUM_REGS);

    typedef logic [XLEN-1:0]   xlen_t;      // data or address word
    typedef logic [REG_AW-1:0] reg_addr_t;  // integer register index
    typedef logic [3:0]        wb_sel_t;    // writeback source
    typedef logic [2:0]        csr_cmd_t;   // csr command from decode

    // writeback source codes, anything unlisted falls back to the alu
    localparam wb_sel_t WB_ALU   = 4'd0;
    localparam wb_sel_t WB_MEMB  = 4'd1;  // signed byte load
    localparam wb_sel_t WB_MEMBU = 4'd2;  // unsigned byte load
    localparam wb_sel_t WB_MEMH  = 4'd3;  // signed halfword load
    localparam wb_sel_t WB_MEMHU = 4'd4;  // unsigned halfword load
    localparam wb_sel_t WB_MEMW  = 4'd5;
    localparam wb_sel_t WB_PC    = 4'd6;  // link value, pc + 4
    localparam wb_sel_t WB_CSR   = 4'd7;

    // csr commands
    localparam csr_cmd_t CSR_NONE  = 3'd0;
    localparam csr_cmd_t CSR_W     = 3'd1;  // csrrw
    localparam csr_cmd_t CSR_S     = 3'd2;  // csrrs
    localparam csr_cmd_t CSR_C     = 3'd3;  // csrrc
    localparam csr_cmd_t CSR_ECALL = 3'd4;
    localparam csr_cmd_t CSR_MRET  = 3'd5;
    localparam csr_cmd_t CSR_SRET  = 3'd6;

endpackage

/* source/wb_pipe_pkg.sv */
package wb_pipe_pkg;

    localparam int RETIRE_DEPTH = 4;  // entries between select and writer
    localparam int COUNT_W      = 32;

    // one extra bit so a full queue is distinct from an empty one
    localparam int LEVEL_W = $clog2(RETIRE_DEPTH) + 1;

    typedef logic [COUNT_W-1:0] retire_count_t;  // retired instructions
    typedef logic [LEVEL_W-1:0] queue_level_t;   // queue occupancy

endpackage

/* source/wb_result_select.sv */
`timescale 1ns/1ps

module wb_result_select (
    input  logic                  clk,
    input  logic                  reset_i,

    input  logic                  op_valid_i,
    input  rv_isa_pkg::xlen_t     op_pc_i,
    input  rv_isa_pkg::wb_sel_t   op_wb_sel_i,
    input  rv_isa_pkg::csr_cmd_t  op_csr_cmd_i,
    input  logic                  op_br_flg_i,
    input  logic                  op_jmp_flg_i,
    input  logic                  op_rf_wen_i,
    input  rv_isa_pkg::reg_addr_t op_wb_addr_i,
    input  rv_isa_pkg::xlen_t     op_alu_out_i,
    input  rv_isa_pkg::xlen_t     op_mem_rdata_i,
    input  rv_isa_pkg::xlen_t     op_csr_rdata_i,
    input  rv_isa_pkg::xlen_t     op_br_target_i,
    input  rv_isa_pkg::xlen_t     op_trap_vector_i,
    output logic                  op_ready_o,

    output logic                  sel_valid_o,
    output rv_isa_pkg::xlen_t     sel_pc_o,
    output logic                  sel_wen_o,
    output rv_isa_pkg::reg_addr_t sel_addr_o,
    output rv_isa_pkg::xlen_t     sel_data_o,
    output rv_isa_pkg::xlen_t     sel_next_pc_o,
    output logic                  sel_redirect_o,
    input  logic                  sel_ready_i
);

    import rv_isa_pkg::*;

    xlen_t pc_plus4;
    xlen_t wb_data;
    xlen_t next_pc;
    logic  is_trap;
    logic  redirect;
    logic  accept;

    assign pc_plus4 = op_pc_i + xlen_t'(4);

    always_comb begin
        case (op_wb_sel_i)
            WB_ALU:   wb_data = op_alu_out_i;
            WB_MEMB:  wb_data = {{24{op_mem_rdata_i[7]}}, op_mem_rdata_i[7:0]};
            WB_MEMBU: wb_data = {24'b0, op_mem_rdata_i[7:0]};
            WB_MEMH:  wb_data = {{16{op_mem_rdata_i[15]}}, op_mem_rdata_i[15:0]};
            WB_MEMHU: wb_data = {16'b0, op_mem_rdata_i[15:0]};
            WB_MEMW:  wb_data = op_mem_rdata_i;
            WB_PC:    wb_data = pc_plus4;
            WB_CSR:   wb_data = op_csr_rdata_i;
            default:  wb_data = op_alu_out_i;
        endcase
    end

    assign is_trap = (op_csr_cmd_i == CSR_ECALL) ||
                     (op_csr_cmd_i == CSR_MRET) ||
                     (op_csr_cmd_i == CSR_SRET);

    // branch wins over jump, jump over trap
    assign next_pc = op_br_flg_i  ? op_br_target_i   :
                     op_jmp_flg_i ? op_alu_out_i     :  // jalr/jal target from alu
                     is_trap      ? op_trap_vector_i :
                                    pc_plus4;

    assign redirect = op_br_flg_i || op_jmp_flg_i || is_trap;

    assign op_ready_o = !sel_valid_o || sel_ready_i;  // slot empty or draining
    assign accept     = op_valid_i && op_ready_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            sel_valid_o <= 1'b0;
        end else if (accept) begin
            sel_valid_o <= 1'b1;
        end else if (sel_ready_i) begin
            sel_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            sel_pc_o       <= op_pc_i;
            sel_wen_o      <= op_rf_wen_i;
            sel_addr_o     <= op_wb_addr_i;
            sel_data_o     <= wb_data;
            sel_next_pc_o  <= next_pc;
            sel_redirect_o <= redirect;
        end
    end

endmodule

/* source/retire_queue.sv */
`timescale 1ns/1ps

module retire_queue #(
    parameter int DEPTH = wb_pipe_pkg::RETIRE_DEPTH
) (
    input  logic                  clk,
    input  logic                  reset_i,

    input  logic                  push_valid_i,
    input  rv_isa_pkg::xlen_t     push_pc_i,
    input  logic                  push_wen_i,
    input  rv_isa_pkg::reg_addr_t push_addr_i,
    input  rv_isa_pkg::xlen_t     push_data_i,
    input  rv_isa_pkg::xlen_t     push_next_pc_i,
    input  logic                  push_redirect_i,
    output logic                  push_ready_o,

    output logic                  pop_valid_o,
    output rv_isa_pkg::xlen_t     pop_pc_o,
    output logic                  pop_wen_o,
    output rv_isa_pkg::reg_addr_t pop_addr_o,
    output rv_isa_pkg::xlen_t     pop_data_o,
    output rv_isa_pkg::xlen_t     pop_next_pc_o,
    output logic                  pop_redirect_o,
    input  logic                  pop_ready_i
);

    import rv_isa_pkg::*;
    import wb_pipe_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    xlen_t     pc_mem      [DEPTH];
    logic      wen_mem     [DEPTH];
    reg_addr_t addr_mem    [DEPTH];
    xlen_t     data_mem    [DEPTH];
    xlen_t     next_pc_mem [DEPTH];
    logic      redir_mem   [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    queue_level_t     level;
    logic             push;
    logic             pop;

    assign push_ready_o = (level != queue_level_t'(DEPTH));
    assign pop_valid_o  = (level != '0);
    assign push         = push_valid_i && push_ready_o;
    assign pop          = pop_valid_o && pop_ready_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop) begin
                level <= level + 1'b1;
            end else if (pop && !push) begin
                level <= level - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr]      <= push_pc_i;
            wen_mem[wr_ptr]     <= push_wen_i;
            addr_mem[wr_ptr]    <= push_addr_i;
            data_mem[wr_ptr]    <= push_data_i;
            next_pc_mem[wr_ptr] <= push_next_pc_i;
            redir_mem[wr_ptr]   <= push_redirect_i;
        end
    end

    assign pop_pc_o       = pc_mem[rd_ptr];
    assign pop_wen_o      = wen_mem[rd_ptr];
    assign pop_addr_o     = addr_mem[rd_ptr];
    assign pop_data_o     = data_mem[rd_ptr];
    assign pop_next_pc_o  = next_pc_mem[rd_ptr];
    assign pop_redirect_o = redir_mem[rd_ptr];

endmodule

/* source/regfile_writer.sv */
`timescale 1ns/1ps

module regfile_writer (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       stall_i,

    input  logic                       q_valid_i,
    input  rv_isa_pkg::xlen_t          q_pc_i,
    input  logic                       q_wen_i,
    input  rv_isa_pkg::reg_addr_t      q_addr_i,
    input  rv_isa_pkg::xlen_t          q_data_i,
    input  rv_isa_pkg::xlen_t          q_next_pc_i,
    input  logic                       q_redirect_i,
    output logic                       q_ready_o,

    output logic                       retire_valid_o,
    output rv_isa_pkg::xlen_t          retire_pc_o,
    output rv_isa_pkg::xlen_t          next_pc_o,
    output logic                       redirect_o,
    output wb_pipe_pkg::retire_count_t retire_count_o,

    input  rv_isa_pkg::reg_addr_t      rf_raddr_i,
    output rv_isa_pkg::xlen_t          rf_rdata_o
);

    import rv_isa_pkg::*;
    import wb_pipe_pkg::*;

    xlen_t regs [NUM_REGS];
    logic  pop;

    assign q_ready_o = !stall_i;  // writeback port busy while stalled
    assign pop       = q_valid_i && q_ready_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (pop && q_wen_i && (q_addr_i != '0)) begin
            regs[q_addr_i] <= q_data_i;  // x0 is never written
        end
    end

    assign rf_rdata_o = (rf_raddr_i == '0) ? '0 : regs[rf_raddr_i];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            retire_valid_o <= 1'b0;
            retire_count_o <= '0;
        end else begin
            retire_valid_o <= pop;
            if (pop) begin
                retire_count_o <= retire_count_o + retire_count_t'(1);
            end
        end
    end

    // retired instruction's values, held until the next pop
    always_ff @(posedge clk) begin
        if (pop) begin
            retire_pc_o <= q_pc_i;
            next_pc_o   <= q_next_pc_i;
            redirect_o  <= q_redirect_i;
        end
    end

endmodule

/* source/wb_subsystem.sv */
`timescale 1ns/1ps

module wb_subsystem (
    input  logic                       clk,
    input  logic                       reset_i,

    input  logic                       op_valid_i,
    input  rv_isa_pkg::xlen_t          op_pc_i,
    input  rv_isa_pkg::wb_sel_t        op_wb_sel_i,
    input  rv_isa_pkg::csr_cmd_t       op_csr_cmd_i,
    input  logic                       op_br_flg_i,
    input  logic                       op_jmp_flg_i,
    input  logic                       op_rf_wen_i,
    input  rv_isa_pkg::reg_addr_t      op_wb_addr_i,
    input  rv_isa_pkg::xlen_t          op_alu_out_i,
    input  rv_isa_pkg::xlen_t          op_mem_rdata_i,
    input  rv_isa_pkg::xlen_t          op_csr_rdata_i,
    input  rv_isa_pkg::xlen_t          op_br_target_i,
    input  rv_isa_pkg::xlen_t          op_trap_vector_i,
    output logic                       op_ready_o,

    input  logic                       stall_i,
    output logic                       retire_valid_o,
    output rv_isa_pkg::xlen_t          retire_pc_o,
    output rv_isa_pkg::xlen_t          next_pc_o,
    output logic                       redirect_o,
    output wb_pipe_pkg::retire_count_t retire_count_o,

    input  rv_isa_pkg::reg_addr_t      rf_raddr_i,
    output rv_isa_pkg::xlen_t          rf_rdata_o
);

    import rv_isa_pkg::*;
    import wb_pipe_pkg::*;

    logic      sel_valid;
    xlen_t     sel_pc;
    logic      sel_wen;
    reg_addr_t sel_addr;
    xlen_t     sel_data;
    xlen_t     sel_next_pc;
    logic      sel_redirect;
    logic      sel_ready;

    logic      q_valid;
    xlen_t     q_pc;
    logic      q_wen;
    reg_addr_t q_addr;
    xlen_t     q_data;
    xlen_t     q_next_pc;
    logic      q_redirect;
    logic      q_ready;

    wb_result_select u_select (
        .clk              (clk),
        .reset_i          (reset_i),
        .op_valid_i       (op_valid_i),
        .op_pc_i          (op_pc_i),
        .op_wb_sel_i      (op_wb_sel_i),
        .op_csr_cmd_i     (op_csr_cmd_i),
        .op_br_flg_i      (op_br_flg_i),
        .op_jmp_flg_i     (op_jmp_flg_i),
        .op_rf_wen_i      (op_rf_wen_i),
        .op_wb_addr_i     (op_wb_addr_i),
        .op_alu_out_i     (op_alu_out_i),
        .op_mem_rdata_i   (op_mem_rdata_i),
        .op_csr_rdata_i   (op_csr_rdata_i),
        .op_br_target_i   (op_br_target_i),
        .op_trap_vector_i (op_trap_vector_i),
        .op_ready_o       (op_ready_o),
        .sel_valid_o      (sel_valid),
        .sel_pc_o         (sel_pc),
        .sel_wen_o        (sel_wen),
        .sel_addr_o       (sel_addr),
        .sel_data_o       (sel_data),
        .sel_next_pc_o    (sel_next_pc),
        .sel_redirect_o   (sel_redirect),
        .sel_ready_i      (sel_ready)
    );

    retire_queue #(
        .DEPTH (RETIRE_DEPTH)
    ) u_queue (
        .clk             (clk),
        .reset_i         (reset_i),
        .push_valid_i    (sel_valid),
        .push_pc_i       (sel_pc),
        .push_wen_i      (sel_wen),
        .push_addr_i     (sel_addr),
        .push_data_i     (sel_data),
        .push_next_pc_i  (sel_next_pc),
        .push_redirect_i (sel_redirect),
        .push_ready_o    (sel_ready),
        .pop_valid_o     (q_valid),
        .pop_pc_o        (q_pc),
        .pop_wen_o       (q_wen),
        .pop_addr_o      (q_addr),
        .pop_data_o      (q_data),
        .pop_next_pc_o   (q_next_pc),
        .pop_redirect_o  (q_redirect),
        .pop_ready_i     (q_ready)
    );

    regfile_writer u_writer (
        .clk            (clk),
        .reset_i        (reset_i),
        .stall_i        (stall_i),
        .q_valid_i      (q_valid),
        .q_pc_i         (q_pc),
        .q_wen_i        (q_wen),
        .q_addr_i       (q_addr),
        .q_data_i       (q_data),
        .q_next_pc_i    (q_next_pc),
        .q_redirect_i   (q_redirect),
        .q_ready_o      (q_ready),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .next_pc_o      (next_pc_o),
        .redirect_o     (redirect_o),
        .retire_count_o (retire_count_o),
        .rf_raddr_i     (rf_raddr_i),
        .rf_rdata_o     (rf_rdata_o)
    );

endmodule

/* bench/wb_subsystem_properties.sv */
`timescale 1ns/1ps

module wb_subsystem_properties (
    input logic                  clk,
    input logic                  reset_i,
    input logic                  op_valid_i,
    input logic                  op_ready_o,
    input rv_isa_pkg::xlen_t     op_pc_i,
    input rv_isa_pkg::wb_sel_t   op_wb_sel_i,
    input rv_isa_pkg::csr_cmd_t  op_csr_cmd_i,
    input logic                  op_br_flg_i,
    input logic                  op_jmp_flg_i,
    input logic                  op_rf_wen_i,
    input rv_isa_pkg::reg_addr_t op_wb_addr_i,
    input rv_isa_pkg::xlen_t     op_alu_out_i,
    input rv_isa_pkg::xlen_t     op_mem_rdata_i,
    input rv_isa_pkg::xlen_t     op_csr_rdata_i,
    input rv_isa_pkg::xlen_t     op_br_target_i,
    input rv_isa_pkg::xlen_t     op_trap_vector_i,
    input logic                  stall_i,
    input logic                  retire_valid_o
);

    int fails = 0;  // read by the testbench at the end

    // a pending transfer keeps its fields
    assert property (@(posedge clk) disable iff (reset_i)
        op_valid_i && !op_ready_o |=> $stable({op_pc_i, op_wb_sel_i, op_csr_cmd_i,
            op_br_flg_i, op_jmp_flg_i, op_rf_wen_i, op_wb_addr_i, op_alu_out_i,
            op_mem_rdata_i, op_csr_rdata_i, op_br_target_i, op_trap_vector_i}))
        else begin
            $error("op fields changed while the transfer was pending");
            fails++;
        end

    assert property (@(posedge clk) reset_i |=> !retire_valid_o)
        else begin
            $error("retire_valid_o high after a reset edge");
            fails++;
        end

    assert property (@(posedge clk) disable iff (reset_i) stall_i |=> !retire_valid_o)
        else begin
            $error("retirement while the writeback port was stalled");
            fails++;
        end

endmodule

bind wb_subsystem wb_subsystem_properties u_props (.*);

/* bench/wb_subsystem_tb.sv */
`timescale 1ns/1ps

module wb_subsystem_tb;

    import rv_isa_pkg::*;
    import wb_pipe_pkg::*;

    localparam int NUM_OPS  = 300;
    localparam int WATCHDOG = NUM_OPS * 20 + 100;  // clock periods

    typedef struct {
        xlen_t     pc;
        xlen_t     next_pc;
        logic      redirect;
        logic      wen;
        reg_addr_t addr;
        xlen_t     data;
        int        edge_n;  // acceptance edge
    } entry_t;

    logic          clk = 1'b0;
    logic          reset_i, op_valid_i, op_br_flg_i, op_jmp_flg_i, op_rf_wen_i, stall_i;
    xlen_t         op_pc_i, op_alu_out_i, op_mem_rdata_i, op_csr_rdata_i;
    xlen_t         op_br_target_i, op_trap_vector_i;
    wb_sel_t       op_wb_sel_i;
    csr_cmd_t      op_csr_cmd_i;
    reg_addr_t     op_wb_addr_i, rf_raddr_i;
    logic          op_ready_o, retire_valid_o, redirect_o;
    xlen_t         retire_pc_o, next_pc_o, rf_rdata_o;
    retire_count_t retire_count_o;

    logic [31:0]   lfsr = 32'd72;
    entry_t        model_q[$];
    xlen_t         model_rf [NUM_REGS] = '{default: '0};
    retire_count_t exp_count = '0;
    int            cyc = 0, accepted = 0, retired = 0, errors = 0, checks = 0, mark = 0;
    logic          hold = 1'b0, latency_mode = 1'b0, saw_full = 1'b0;
    logic [15:0]   sel_seen = '0;

    wb_subsystem i_wb_subsystem (.*);

    always #50 clk = ~clk;
    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic trap_cmd(input csr_cmd_t cmd);
        return (cmd == CSR_ECALL) || (cmd == CSR_MRET) || (cmd == CSR_SRET);
    endfunction

    function automatic xlen_t wb_value(input wb_sel_t sel, input xlen_t pc, input xlen_t alu,
                                       input xlen_t mem, input xlen_t csr);
        case (sel)
            WB_MEMB:  return $signed({mem[7:0], 24'b0}) >>> 24;
            WB_MEMBU: return {mem[7:0], 24'b0} >> 24;
            WB_MEMH:  return $signed({mem[15:0], 16'b0}) >>> 16;
            WB_MEMHU: return {mem[15:0], 16'b0} >> 16;
            WB_MEMW:  return mem;
            WB_PC:    return pc + 32'd4;
            WB_CSR:   return csr;
            default:  return alu;  // WB_ALU and the unused codes
        endcase
    endfunction

    function automatic xlen_t target_pc(input logic br, input logic jmp, input csr_cmd_t cmd,
                                        input xlen_t pc, input xlen_t br_target,
                                        input xlen_t alu, input xlen_t trap_vec);
        if (br) return br_target;
        if (jmp) return alu;
        if (trap_cmd(cmd)) return trap_vec;
        return pc + 32'd4;
    endfunction

    task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input retire_count_t exp,
                               input retire_count_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    task automatic drive_fields();
        op_pc_i          <= lfsr_bits(32);
        op_wb_sel_i      <= wb_sel_t'(lfsr_bits(4));
        op_csr_cmd_i     <= csr_cmd_t'(lfsr_bits(3));
        op_br_flg_i      <= (lfsr_bits(2) == 0);
        op_jmp_flg_i     <= (lfsr_bits(2) == 0);
        op_rf_wen_i      <= 1'(lfsr_bits(1));
        op_wb_addr_i     <= reg_addr_t'(lfsr_bits(5));
        op_alu_out_i     <= lfsr_bits(32);
        op_mem_rdata_i   <= lfsr_bits(32);
        op_csr_rdata_i   <= lfsr_bits(32);
        op_br_target_i   <= lfsr_bits(32);
        op_trap_vector_i <= lfsr_bits(32);
    endtask

    task automatic read_regs();
        for (int a = 0; a < NUM_REGS; a++) begin
            @(posedge clk);
            rf_raddr_i <= reg_addr_t'(a);
            @(negedge clk);
            check_word($sformatf("rf_rdata_o[x%0d]", a), model_rf[a], rf_rdata_o);
        end
    endtask

    task automatic drain();
        while (retired != accepted) @(posedge clk);
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, errors - mark);
        mark = errors;
    endtask

    // outputs are stable mid-cycle, so acceptance and retirement are sampled here
    always @(negedge clk) begin
        entry_t e;
        if (!reset_i) begin
            hold = op_valid_i && !op_ready_o;
            if (!op_ready_o) saw_full = 1'b1;  // producer slot and queue both full
            if (op_valid_i && op_ready_o) begin
                e.pc       = op_pc_i;
                e.next_pc  = target_pc(op_br_flg_i, op_jmp_flg_i, op_csr_cmd_i, op_pc_i,
                                       op_br_target_i, op_alu_out_i, op_trap_vector_i);
                e.redirect = op_br_flg_i || op_jmp_flg_i || trap_cmd(op_csr_cmd_i);
                e.wen      = op_rf_wen_i;
                e.addr     = op_wb_addr_i;
                e.data     = wb_value(op_wb_sel_i, op_pc_i, op_alu_out_i, op_mem_rdata_i,
                                      op_csr_rdata_i);
                e.edge_n   = cyc + 1;
                model_q.push_back(e);
                sel_seen[op_wb_sel_i] = 1'b1;
                accepted++;
            end
            if (retire_valid_o) begin
                if (model_q.size() == 0) begin
                    errors++;
                    $display("retire_valid_o pulsed with nothing outstanding at %0t", $time);
                end else begin
                    e = model_q.pop_front();
                    check_word("retire_pc_o", e.pc, retire_pc_o);
                    check_word("next_pc_o", e.next_pc, next_pc_o);
                    check_flag("redirect_o", e.redirect, redirect_o);
                    if (e.wen && e.addr != '0) model_rf[e.addr] = e.data;
                    if (latency_mode) begin
                        check_count("retire latency", 2, retire_count_t'(cyc - e.edge_n));
                    end
                    exp_count++;
                    retired++;
                end
            end
            check_count("retire_count_o", exp_count, retire_count_o);
        end
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("run timed out after %0d clock periods", WATCHDOG);
        $display("sim failed");
        $finish;
    end

    initial begin
        reset_i    <= 1'b1;
        op_valid_i <= 1'b0;
        stall_i    <= 1'b0;
        rf_raddr_i <= '0;
        drive_fields();
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        check_flag("op_ready_o", 1'b1, op_ready_o);
        check_flag("retire_valid_o", 1'b0, retire_valid_o);
        check_count("retire_count_o", '0, retire_count_o);
        read_regs();
        end_test("reset_values");

        while (accepted < NUM_OPS) begin
            @(posedge clk);
            stall_i <= (lfsr_bits(2) == 0);
            if (!hold) begin
                if (accepted < NUM_OPS) begin
                    op_valid_i <= (lfsr_bits(3) != 0);
                    drive_fields();
                end else begin
                    op_valid_i <= 1'b0;
                end
            end
        end
        @(posedge clk);
        stall_i <= 1'b0;
        drain();
        if (!saw_full) begin
            errors++;
            $display("op_ready_o never went low although the queue filled up");
        end
        end_test("random_retire");

        latency_mode = 1'b1;
        repeat (4) begin
            @(posedge clk);
            op_valid_i <= 1'b1;
            drive_fields();
            @(posedge clk);
            op_valid_i <= 1'b0;
            drain();
        end
        latency_mode = 1'b0;
        end_test("fixed_latency");

        read_regs();
        if (sel_seen[7:0] != 8'hFF) begin
            errors++;
            $display("not every writeback selector code was exercised");
        end
        end_test("register_readback");

        @(negedge clk);
        check_count("retire_count_o", retire_count_t'(accepted), retire_count_o);
        if (i_wb_subsystem.u_props.fails != 0) begin
            errors += i_wb_subsystem.u_props.fails;
            $display("%0d assertion failures were seen", i_wb_subsystem.u_props.fails);
        end
        end_test("retire_count");

        $display("%0d checks, %0d errors, %0d retired", checks, errors, retired);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* wb_subsystem.f */
source/rv_isa_pkg.sv
source/wb_pipe_pkg.sv
source/wb_result_select.sv
source/retire_queue.sv
source/regfile_writer.sv
source/wb_subsystem.sv
bench/wb_subsystem_properties.sv
bench/wb_subsystem_tb.sv
